// File: Bender.yml
package:
  name: periph

sources:
  - src/periph_pkg.sv
  - src/reg_decode.sv
  - src/cmp_timer.sv
  - src/irq_gateway.sv
  - src/plic_core.sv
  - src/periph_top.sv
  - target: test
    files:
      - verification/periph_tb.sv

// File: sim.f
src/periph_pkg.sv
src/reg_decode.sv
src/cmp_timer.sv
src/irq_gateway.sv
src/plic_core.sv
src/periph_top.sv
verification/periph_tb.sv

// File: src/cmp_timer.sv
module cmp_timer (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              sel_i,
    input  logic                              write_i,
    input  periph_pkg::addr_t                 addr_i,
    input  periph_pkg::data_t                 wdata_i,
    output periph_pkg::data_t                 rdata_o,
    output logic [periph_pkg::NUM_TIMERS-1:0] match_o
);

    periph_pkg::tmr_state_e            state_q [periph_pkg::NUM_TIMERS];
    periph_pkg::data_t                 count_q [periph_pkg::NUM_TIMERS];
    periph_pkg::data_t                 cmp_q   [periph_pkg::NUM_TIMERS];
    logic [periph_pkg::NUM_TIMERS-1:0] en_q;
    logic [periph_pkg::NUM_TIMERS-1:0] match_q;
    periph_pkg::addr_t                 chan;
    periph_pkg::addr_t                 reg_off;
    periph_pkg::data_t                 rdata_d;
    periph_pkg::data_t                 rdata_q;
    logic                              wr;
    logic                              rd;

    assign chan    = periph_pkg::addr_t'(addr_i / periph_pkg::TMR_STRIDE);
    assign reg_off = periph_pkg::addr_t'(addr_i % periph_pkg::TMR_STRIDE);
    assign wr      = sel_i && write_i;
    assign rd      = sel_i && !write_i;

    // ----------------------------------------------------------
    // Channel FSMs, counters and bus writes
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
                state_q[c] <= periph_pkg::IDLE;
                count_q[c] <= '0;
                cmp_q[c]   <= '0;
            end
            en_q    <= '0;
            match_q <= '0;
        end else begin
            for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
                match_q[c] <= 1'b0;
                case (state_q[c])
                    periph_pkg::IDLE: begin
                        if (en_q[c]) state_q[c] <= periph_pkg::RUN;
                    end
                    periph_pkg::RUN: begin
                        if (!en_q[c]) begin
                            state_q[c] <= periph_pkg::IDLE;
                        end else if (count_q[c] == cmp_q[c]) begin
                            count_q[c] <= '0;
                            match_q[c] <= 1'b1;
                        end else begin
                            count_q[c] <= count_q[c] + 1'b1;
                        end
                    end
                    default: state_q[c] <= periph_pkg::IDLE;
                endcase
                // A bus write wins over the counter update
                if (wr && chan == periph_pkg::addr_t'(c)) begin
                    case (reg_off)
                        periph_pkg::TMR_CTRL:  en_q[c]    <= wdata_i[0];
                        periph_pkg::TMR_COUNT: count_q[c] <= wdata_i;
                        periph_pkg::TMR_CMP:   cmp_q[c]   <= wdata_i;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Read mux, ctrl shows enable in bit 0 and running in bit 1
    always_comb begin
        rdata_d = '0;
        for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
            if (chan == periph_pkg::addr_t'(c)) begin
                case (reg_off)
                    periph_pkg::TMR_CTRL: rdata_d = periph_pkg::data_t'(
                        {state_q[c] == periph_pkg::RUN, en_q[c]});
                    periph_pkg::TMR_COUNT: rdata_d = count_q[c];
                    periph_pkg::TMR_CMP:   rdata_d = cmp_q[c];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) rdata_q <= rdata_d;
    end

    assign rdata_o = rdata_q;
    assign match_o = match_q;

endmodule

// File: src/irq_gateway.sv
module irq_gateway (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::src_vec_t src_i,
    input  periph_pkg::src_vec_t claim_i,
    input  periph_pkg::src_vec_t complete_i,
    output periph_pkg::src_vec_t pending_o
);

    periph_pkg::src_vec_t src_q;
    periph_pkg::src_vec_t rise;
    periph_pkg::src_vec_t pending_d;
    periph_pkg::src_vec_t pending_q;
    periph_pkg::src_vec_t in_service_q;

    assign rise = src_i & ~src_q;

    // Edge sources latch a rising edge, level sources follow the line
    // In-service sources are blocked, so edges seen then are lost
    assign pending_d = ((periph_pkg::EDGE_SRC_MASK & (pending_q | rise)) |
                        (~periph_pkg::EDGE_SRC_MASK & src_i))
                       & ~in_service_q & ~claim_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q        <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            src_q        <= src_i;
            pending_q    <= pending_d;
            in_service_q <= (in_service_q | claim_i) & ~complete_i;
        end
    end

    assign pending_o = pending_q;

endmodule

// File: src/periph_pkg.sv
package periph_pkg;

    // ----------------------------------------------------------
    // Register bus
    // ----------------------------------------------------------
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Top nibble of the address selects the page
    localparam logic [3:0] TIMER_BASE = 4'h0;
    localparam logic [3:0] PLIC_BASE  = 4'h1;

    // Returned for pages with no peripheral behind them
    localparam data_t ERR_RDATA = 32'hdead_beef;

    // ----------------------------------------------------------
    // Interrupt sources
    // ----------------------------------------------------------
    localparam int NUM_TIMERS  = 2;
    localparam int NUM_EXT_SRC = 8;
    localparam int NUM_SRC     = NUM_TIMERS + NUM_EXT_SRC;

    typedef logic [NUM_SRC-1:0] src_vec_t;

    localparam int SRC_ID_W = 4;
    typedef logic [SRC_ID_W-1:0] src_id_t;

    // Bit i is source ID i+1, timers first, then external lines
    // Timers and external lines 4..7 are edge triggered
    localparam src_vec_t EDGE_SRC_MASK = 10'b11_1100_0011;

    localparam int PRIO_W = 3;
    typedef logic [PRIO_W-1:0] prio_t;

    // ----------------------------------------------------------
    // Register offsets within a page
    // ----------------------------------------------------------
    localparam addr_t TMR_CTRL   = 12'h000;
    localparam addr_t TMR_COUNT  = 12'h004;
    localparam addr_t TMR_CMP    = 12'h008;
    localparam addr_t TMR_STRIDE = 12'h010;

    localparam addr_t PLIC_PRIO_BASE = 12'h000;
    localparam addr_t PLIC_ENABLE    = 12'h080;
    localparam addr_t PLIC_THRESH    = 12'h084;
    localparam addr_t PLIC_CLAIM     = 12'h088;

    typedef enum logic {IDLE, RUN} tmr_state_e;

endpackage

// File: src/periph_top.sv
module periph_top (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               req_valid_i,
    input  logic                               req_write_i,
    input  periph_pkg::addr_t                  req_addr_i,
    input  periph_pkg::data_t                  req_wdata_i,
    output logic                               rsp_valid_o,
    output logic                               rsp_error_o,
    output periph_pkg::data_t                  rsp_rdata_o,
    input  logic [periph_pkg::NUM_EXT_SRC-1:0] ext_irq_i,
    output logic                               irq_o
);

    logic                              tmr_sel;
    logic                              plic_sel;
    logic                              bus_write;
    periph_pkg::addr_t                 bus_addr;
    periph_pkg::data_t                 bus_wdata;
    periph_pkg::data_t                 tmr_rdata;
    periph_pkg::data_t                 plic_rdata;
    logic [periph_pkg::NUM_TIMERS-1:0] tmr_match;
    periph_pkg::src_vec_t              irq_src;
    periph_pkg::src_vec_t              pending;
    periph_pkg::src_vec_t              claim_src;
    periph_pkg::src_vec_t              complete_src;

    // Timers take IDs 1..2, external lines follow from ID 3
    assign irq_src = {ext_irq_i, tmr_match};

    reg_decode i_reg_decode (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .req_valid_i  ( req_valid_i  ),
        .req_write_i  ( req_write_i  ),
        .req_addr_i   ( req_addr_i   ),
        .req_wdata_i  ( req_wdata_i  ),
        .rsp_valid_o  ( rsp_valid_o  ),
        .rsp_rdata_o  ( rsp_rdata_o  ),
        .rsp_error_o  ( rsp_error_o  ),
        .tmr_sel_o    ( tmr_sel      ),
        .plic_sel_o   ( plic_sel     ),
        .write_o      ( bus_write    ),
        .addr_o       ( bus_addr     ),
        .wdata_o      ( bus_wdata    ),
        .tmr_rdata_i  ( tmr_rdata    ),
        .plic_rdata_i ( plic_rdata   )
    );

    cmp_timer i_cmp_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .sel_i   ( tmr_sel   ),
        .write_i ( bus_write ),
        .addr_i  ( bus_addr  ),
        .wdata_i ( bus_wdata ),
        .rdata_o ( tmr_rdata ),
        .match_o ( tmr_match )
    );

    irq_gateway i_irq_gateway (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .src_i      ( irq_src      ),
        .claim_i    ( claim_src    ),
        .complete_i ( complete_src ),
        .pending_o  ( pending      )
    );

    plic_core i_plic_core (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .sel_i      ( plic_sel     ),
        .write_i    ( bus_write    ),
        .addr_i     ( bus_addr     ),
        .wdata_i    ( bus_wdata    ),
        .pending_i  ( pending      ),
        .rdata_o    ( plic_rdata   ),
        .claim_o    ( claim_src    ),
        .complete_o ( complete_src ),
        .irq_o      ( irq_o        )
    );

endmodule

// File: src/plic_core.sv
module plic_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 sel_i,
    input  logic                 write_i,
    input  periph_pkg::addr_t    addr_i,
    input  periph_pkg::data_t    wdata_i,
    input  periph_pkg::src_vec_t pending_i,
    output periph_pkg::data_t    rdata_o,
    output periph_pkg::src_vec_t claim_o,
    output periph_pkg::src_vec_t complete_o,
    output logic                 irq_o
);

    periph_pkg::prio_t    prio_q [periph_pkg::NUM_SRC];
    periph_pkg::src_vec_t enable_q;
    periph_pkg::prio_t    thresh_q;
    periph_pkg::src_vec_t qualified;
    periph_pkg::src_id_t  best_id;
    periph_pkg::prio_t    best_prio;
    periph_pkg::addr_t    prio_idx;
    periph_pkg::data_t    rdata_d;
    periph_pkg::data_t    rdata_q;
    periph_pkg::src_vec_t claim_q;
    periph_pkg::src_vec_t complete_q;
    logic                 irq_q;
    logic                 is_prio;
    logic                 claim_hit;
    logic                 rd;
    logic                 wr;

    function automatic periph_pkg::src_vec_t id_onehot(input periph_pkg::src_id_t id);
        periph_pkg::src_vec_t vec;
        vec = '0;
        if (id != '0 && id <= periph_pkg::NUM_SRC) vec[id - 1'b1] = 1'b1;
        return vec;
    endfunction

    assign rd        = sel_i && !write_i;
    assign wr        = sel_i && write_i;
    assign claim_hit = (addr_i == periph_pkg::PLIC_CLAIM);
    assign is_prio   = (addr_i < periph_pkg::PLIC_ENABLE) && (addr_i[1:0] == 2'b00);
    assign prio_idx  = (addr_i - periph_pkg::PLIC_PRIO_BASE) >> 2;

    // ----------------------------------------------------------
    // Source selection
    // ----------------------------------------------------------
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 0; i < periph_pkg::NUM_SRC; i++) begin
            qualified[i] = pending_i[i] && enable_q[i] && (prio_q[i] > thresh_q);
            // Skip a source whose claim is still on its way to the gateway
            if (qualified[i] && !claim_q[i] && (best_id == '0 || prio_q[i] > best_prio)) begin
                best_id   = periph_pkg::src_id_t'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    // ----------------------------------------------------------
    // Registers, enable bit n belongs to ID n
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < periph_pkg::NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            enable_q   <= '0;
            thresh_q   <= '0;
            claim_q    <= '0;
            complete_q <= '0;
            irq_q      <= 1'b0;
        end else begin
            for (int i = 0; i < periph_pkg::NUM_SRC; i++) begin
                if (wr && is_prio && prio_idx == periph_pkg::addr_t'(i + 1))
                    prio_q[i] <= wdata_i[periph_pkg::PRIO_W-1:0];
            end
            if (wr && addr_i == periph_pkg::PLIC_ENABLE) enable_q <= wdata_i[periph_pkg::NUM_SRC:1];
            if (wr && addr_i == periph_pkg::PLIC_THRESH) thresh_q <= wdata_i[periph_pkg::PRIO_W-1:0];
            claim_q    <= (rd && claim_hit) ? id_onehot(best_id) : '0;
            complete_q <= (wr && claim_hit && wdata_i <= periph_pkg::NUM_SRC) ?
                          id_onehot(periph_pkg::src_id_t'(wdata_i)) : '0;
            irq_q      <= |qualified;
        end
    end

    always_comb begin
        rdata_d = '0;
        if (addr_i == periph_pkg::PLIC_ENABLE) begin
            rdata_d = periph_pkg::data_t'({enable_q, 1'b0});
        end else if (addr_i == periph_pkg::PLIC_THRESH) begin
            rdata_d = periph_pkg::data_t'(thresh_q);
        end else if (claim_hit) begin
            rdata_d = periph_pkg::data_t'(best_id);
        end else if (is_prio) begin
            for (int i = 0; i < periph_pkg::NUM_SRC; i++) begin
                if (prio_idx == periph_pkg::addr_t'(i + 1)) rdata_d = periph_pkg::data_t'(prio_q[i]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) rdata_q <= rdata_d;
    end

    assign rdata_o    = rdata_q;
    assign claim_o    = claim_q;
    assign complete_o = complete_q;
    assign irq_o      = irq_q;

    claim_id_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd && claim_hit) |=> (rdata_o <= periph_pkg::NUM_SRC));

endmodule

// File: src/reg_decode.sv
module reg_decode (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  periph_pkg::addr_t req_addr_i,
    input  periph_pkg::data_t req_wdata_i,
    output logic              rsp_valid_o,
    output periph_pkg::data_t rsp_rdata_o,
    output logic              rsp_error_o,
    output logic              tmr_sel_o,
    output logic              plic_sel_o,
    output logic              write_o,
    output periph_pkg::addr_t addr_o,
    output periph_pkg::data_t wdata_o,
    input  periph_pkg::data_t tmr_rdata_i,
    input  periph_pkg::data_t plic_rdata_i
);

    logic [3:0] page;
    logic       valid_q;
    logic       tmr_q;
    logic       plic_q;

    assign page = req_addr_i[periph_pkg::ADDR_W-1 -: 4];

    assign tmr_sel_o  = req_valid_i && (page == periph_pkg::TIMER_BASE);
    assign plic_sel_o = req_valid_i && (page == periph_pkg::PLIC_BASE);
    assign write_o    = req_write_i;
    assign wdata_o    = req_wdata_i;
    // Peers only see the offset within their page
    assign addr_o     = {4'h0, req_addr_i[periph_pkg::ADDR_W-5:0]};

    // Remember the target for the response cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            tmr_q   <= 1'b0;
            plic_q  <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
            tmr_q   <= tmr_sel_o;
            plic_q  <= plic_sel_o;
        end
    end

    assign rsp_valid_o = valid_q;
    assign rsp_error_o = valid_q && !tmr_q && !plic_q;
    assign rsp_rdata_o = tmr_q  ? tmr_rdata_i  :
                         plic_q ? plic_rdata_i : periph_pkg::ERR_RDATA;

    sel_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(tmr_sel_o && plic_sel_o));

endmodule

// File: verification/periph_tb.sv
module periph_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 3000;

    typedef logic [periph_pkg::NUM_SRC*periph_pkg::PRIO_W-1:0] prio_vec_t;

    logic                               clk_i;
    logic                               rst_n_i;
    logic                               req_valid_i;
    logic                               req_write_i;
    periph_pkg::addr_t                  req_addr_i;
    periph_pkg::data_t                  req_wdata_i;
    logic                               rsp_valid_o;
    logic                               rsp_error_o;
    periph_pkg::data_t                  rsp_rdata_o;
    logic [periph_pkg::NUM_EXT_SRC-1:0] ext_irq_i;
    logic                               irq_o;

    // Expected responses in request order
    string             exp_name_q [$];
    int                exp_due_q  [$];
    logic              exp_err_q  [$];
    logic              exp_chk_q  [$];
    periph_pkg::data_t exp_data_q [$];

    // Model of the interrupt controller state
    periph_pkg::src_vec_t model_pend;
    periph_pkg::src_vec_t model_en;
    prio_vec_t            model_prio;
    periph_pkg::prio_t    model_thresh;

    periph_pkg::data_t tmr_cmp [periph_pkg::NUM_TIMERS];
    integer            seed;
    int                cycle_count;
    int                err_count;
    int                test_err_start;
    int                tests_passed;
    int                tests_failed;
    string             current_test;

    periph_top UUT (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_valid_i ( req_valid_i ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_error_o ( rsp_error_o ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .ext_irq_i   ( ext_irq_i   ),
        .irq_o       ( irq_o       )
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Response checker
    // ----------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_count) begin
                assert (rsp_valid_o === 1'b1) else begin
                    $display("Request %s got no response", exp_name_q[0]);
                    err_count++;
                end
                if (rsp_valid_o === 1'b1) begin
                    assert (rsp_error_o === exp_err_q[0]) else begin
                        $display("FAIL %s: expected error %0b, actual %0b",
                                 exp_name_q[0], exp_err_q[0], rsp_error_o);
                        err_count++;
                    end
                    if (exp_chk_q[0]) begin
                        assert (rsp_rdata_o === exp_data_q[0]) else begin
                            $display("FAIL %s: expected %h, actual %h",
                                     exp_name_q[0], exp_data_q[0], rsp_rdata_o);
                            err_count++;
                        end
                    end
                end
                void'(exp_name_q.pop_front());
                void'(exp_due_q.pop_front());
                void'(exp_err_q.pop_front());
                void'(exp_chk_q.pop_front());
                void'(exp_data_q.pop_front());
            end else begin
                assert (rsp_valid_o !== 1'b1) else begin
                    $display("A response arrived with no request outstanding");
                    err_count++;
                end
            end
        end
    end

    // Highest priority above threshold wins and ties go to the lowest ID
    function automatic periph_pkg::src_id_t expected_claim(
        input periph_pkg::src_vec_t pend,
        input periph_pkg::src_vec_t en,
        input prio_vec_t            prio,
        input periph_pkg::prio_t    thresh
    );
        periph_pkg::src_id_t best;
        periph_pkg::prio_t   best_prio;
        periph_pkg::prio_t   p;
        best      = '0;
        best_prio = '0;
        for (int id = 1; id <= periph_pkg::NUM_SRC; id++) begin
            p = prio[(id-1)*periph_pkg::PRIO_W +: periph_pkg::PRIO_W];
            if (pend[id-1] && en[id-1] && p > thresh && (best == '0 || p > best_prio)) begin
                best      = periph_pkg::src_id_t'(id);
                best_prio = p;
            end
        end
        return best;
    endfunction

    function automatic periph_pkg::addr_t plic_addr(input periph_pkg::addr_t off);
        return {periph_pkg::PLIC_BASE, off[7:0]};
    endfunction

    function automatic periph_pkg::addr_t tmr_addr(input int chan, input periph_pkg::addr_t off);
        periph_pkg::addr_t a;
        a = periph_pkg::addr_t'(chan) * periph_pkg::TMR_STRIDE + off;
        return {periph_pkg::TIMER_BASE, a[7:0]};
    endfunction

    // ----------------------------------------------------------
    // Bus and helper tasks
    // ----------------------------------------------------------
    task automatic issue(input logic wr, input periph_pkg::addr_t addr,
                         input periph_pkg::data_t wdata, input logic exp_err,
                         input logic chk, input periph_pkg::data_t exp_data,
                         input string what);
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        exp_name_q.push_back({current_test, "/", what});
        exp_due_q.push_back(cycle_count + 1);
        exp_err_q.push_back(exp_err);
        exp_chk_q.push_back(chk);
        exp_data_q.push_back(exp_data);
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic idle_bus();
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
    endtask

    task automatic write_reg(input periph_pkg::addr_t addr, input periph_pkg::data_t data,
                             input string what);
        issue(1'b1, addr, data, 1'b0, 1'b0, '0, what);
        idle_bus();
    endtask

    task automatic read_reg(input periph_pkg::addr_t addr, input periph_pkg::data_t exp,
                            input string what);
        issue(1'b0, addr, '0, 1'b0, 1'b1, exp, what);
        idle_bus();
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #0.5;
    endtask

    task automatic drain();
        while (exp_due_q.size() != 0) @(posedge clk_i);
        #0.5;
    endtask

    task automatic write_prio(input int id, input periph_pkg::data_t data);
        write_reg(plic_addr(periph_pkg::PLIC_PRIO_BASE + periph_pkg::addr_t'(4 * id)), data,
                  $sformatf("prio %0d", id));
        model_prio[(id-1)*periph_pkg::PRIO_W +: periph_pkg::PRIO_W] = data[periph_pkg::PRIO_W-1:0];
    endtask

    // Enable bit n belongs to source ID n
    task automatic program_enable(input periph_pkg::data_t data);
        write_reg(plic_addr(periph_pkg::PLIC_ENABLE), data, "enable");
        model_en = data[periph_pkg::NUM_SRC:1];
    endtask

    task automatic program_thresh(input periph_pkg::data_t data);
        write_reg(plic_addr(periph_pkg::PLIC_THRESH), data, "threshold");
        model_thresh = data[periph_pkg::PRIO_W-1:0];
    endtask

    task automatic claim_src(output periph_pkg::src_id_t id, input string what);
        id = expected_claim(model_pend, model_en, model_prio, model_thresh);
        read_reg(plic_addr(periph_pkg::PLIC_CLAIM), periph_pkg::data_t'(id), what);
        if (id != '0) model_pend[id-1] = 1'b0;
    endtask

    task automatic complete_src(input int id);
        write_reg(plic_addr(periph_pkg::PLIC_CLAIM), periph_pkg::data_t'(id), "complete");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("FAIL %s/%s: expected %0b, actual %0b", current_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        current_test   = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        drain();
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("Test %-10s ok", current_test);
        end else begin
            tests_failed++;
            $display("Test %-10s %0d errors", current_test, err_count - test_err_start);
        end
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    task automatic readback_regs();
        start_test("readback");
        for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
            tmr_cmp[c] = $random(seed);
            write_reg(tmr_addr(c, periph_pkg::TMR_CMP), tmr_cmp[c], "tmr cmp");
            read_reg(tmr_addr(c, periph_pkg::TMR_CMP), tmr_cmp[c], "tmr cmp");
        end
        write_reg(tmr_addr(1, periph_pkg::TMR_COUNT), 32'h0000_1234, "tmr count");
        read_reg(tmr_addr(1, periph_pkg::TMR_COUNT), 32'h0000_1234, "tmr count");
        write_prio(2, 32'hffff_fffd);
        read_reg(plic_addr(periph_pkg::PLIC_PRIO_BASE + 12'h008), 32'h5, "prio 2");
        write_prio(7, $random(seed));
        read_reg(plic_addr(periph_pkg::PLIC_PRIO_BASE + 12'h01c),
                 periph_pkg::data_t'(model_prio[6*periph_pkg::PRIO_W +: periph_pkg::PRIO_W]),
                 "prio 7");
        program_enable(32'h0000_05a4);
        read_reg(plic_addr(periph_pkg::PLIC_ENABLE), 32'h0000_05a4, "enable");
        program_thresh(32'h5);
        read_reg(plic_addr(periph_pkg::PLIC_THRESH), 32'h5, "threshold");
        finish_test();
    endtask

    task automatic unmapped_access();
        start_test("unmapped");
        issue(1'b0, 12'h3a4, '0, 1'b1, 1'b1, periph_pkg::ERR_RDATA, "read 3a4");
        idle_bus();
        issue(1'b1, 12'hf10, 32'h55, 1'b1, 1'b0, '0, "write f10");
        idle_bus();
        // Mixed requests on back-to-back cycles
        issue(1'b0, tmr_addr(0, periph_pkg::TMR_CMP), '0, 1'b0, 1'b1, tmr_cmp[0], "b2b tmr");
        issue(1'b0, 12'h7fc, '0, 1'b1, 1'b1, periph_pkg::ERR_RDATA, "b2b read 7fc");
        issue(1'b1, 12'h500, 32'h1234, 1'b1, 1'b0, '0, "b2b write 500");
        issue(1'b0, plic_addr(periph_pkg::PLIC_THRESH), '0, 1'b0, 1'b1,
              periph_pkg::data_t'(model_thresh), "b2b threshold");
        issue(1'b0, 12'h2c0, '0, 1'b1, 1'b1, periph_pkg::ERR_RDATA, "b2b read 2c0");
        idle_bus();
        finish_test();
    endtask

    task automatic level_source();
        periph_pkg::src_id_t id;
        start_test("level");
        program_thresh(32'h1);
        write_prio(5, 32'h3);
        program_enable(32'h1 << 5);
        ext_irq_i[2] = 1'b1;
        wait_cycles(1);
        check_bit("irq after 1 cycle", 1'b0, irq_o);
        wait_cycles(1);
        check_bit("irq after 2 cycles", 1'b1, irq_o);
        model_pend[4] = 1'b1;
        claim_src(id, "claim");
        wait_cycles(3);
        check_bit("irq in service", 1'b0, irq_o);
        wait_cycles(5);
        check_bit("still blocked", 1'b0, irq_o);
        complete_src(5);
        wait_cycles(4);
        check_bit("pending again", 1'b1, irq_o);
        model_pend[4] = 1'b1;
        claim_src(id, "reclaim");
        ext_irq_i[2] = 1'b0;
        complete_src(5);
        wait_cycles(4);
        check_bit("irq idle", 1'b0, irq_o);
        finish_test();
    endtask

    task automatic priority_rounds();
        logic [3:0]          lines;
        periph_pkg::src_id_t id;
        start_test("priority");
        program_thresh(32'h3);
        program_enable('1);
        for (int i = 3; i <= 6; i++) begin
            write_prio(i, $random(seed));
        end
        lines = $random(seed);
        if (lines == 4'h0) lines = 4'b1010;
        // External lines 0..3 are the level sources with IDs 3..6
        ext_irq_i[3:0] = lines;
        wait_cycles(3);
        model_pend[5:2] = lines;
        for (int r = 0; r < 5; r++) begin
            claim_src(id, $sformatf("round %0d", r));
            if (id != '0) begin
                ext_irq_i[id-3] = 1'b0;
                complete_src(id);
                wait_cycles(4);
            end
        end
        check_bit("irq with none qualified", 1'b0, irq_o);
        ext_irq_i = '0;
        model_pend[5:2] = '0;
        wait_cycles(3);
        finish_test();
    endtask

    task automatic edge_source();
        periph_pkg::src_id_t id;
        start_test("edge");
        program_thresh(32'h0);
        write_prio(8, 32'h6);
        program_enable(32'h1 << 8);
        ext_irq_i[5] = 1'b1;
        wait_cycles(1);
        ext_irq_i[5] = 1'b0;
        wait_cycles(3);
        check_bit("held after pulse", 1'b1, irq_o);
        model_pend[7] = 1'b1;
        claim_src(id, "claim");
        wait_cycles(2);
        claim_src(id, "second claim");
        // Pulse while in service must be lost
        ext_irq_i[5] = 1'b1;
        wait_cycles(1);
        ext_irq_i[5] = 1'b0;
        wait_cycles(2);
        complete_src(8);
        wait_cycles(4);
        check_bit("no delivery after complete", 1'b0, irq_o);
        claim_src(id, "claim after complete");
        finish_test();
    endtask

    task automatic timer_match();
        periph_pkg::src_id_t id;
        periph_pkg::data_t   cmp;
        start_test("timer");
        cmp = 32'd16 + ($random(seed) & 32'hf);
        program_thresh(32'h1);
        write_prio(2, 32'h5);
        program_enable(32'h1 << 2);
        write_reg(tmr_addr(1, periph_pkg::TMR_COUNT), '0, "count");
        write_reg(tmr_addr(1, periph_pkg::TMR_CMP), cmp, "cmp");
        write_reg(tmr_addr(1, periph_pkg::TMR_CTRL), 32'h1, "start");
        while (irq_o !== 1'b1) wait_cycles(1);
        model_pend[1] = 1'b1;
        claim_src(id, "claim");
        write_reg(tmr_addr(1, periph_pkg::TMR_CTRL), 32'h0, "stop");
        complete_src(2);
        wait_cycles(4);
        check_bit("irq idle", 1'b0, irq_o);
        finish_test();
    endtask

    initial begin
        seed         = 32'h3c18_1f24;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        ext_irq_i    = '0;
        model_pend   = '0;
        model_en     = '0;
        model_prio   = '0;
        model_thresh = '0;
        cycle_count  = 0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        readback_regs();
        unmapped_access();
        level_source();
        priority_rounds();
        edge_source();
        timer_match();
        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
